// ==== design/cpu8_pkg.sv ====
// Shared widths and enums for the 8-bit accumulator CPU
// Referenced from every design file through cpu8_pkg:: scoped names
package cpu8_pkg;

    localparam int data_w = 8;  // Bus and data register width
    localparam int addr_w = 4;  // Address and program counter width

    // Upper nibble of every instruction word
    typedef enum logic [3:0] {
        LDA = 4'd0,   // A <= RAM[addr]
        ADD = 4'd1,   // A <= A + RAM[addr]
        SUB = 4'd2,   // A <= A - RAM[addr]
        STA = 4'd3,   // RAM[addr] <= A
        LDI = 4'd4,   // A <= immediate, zero-extended
        JMP = 4'd5,   // PC <= addr
        JC  = 4'd6,   // PC <= addr if carry set
        JZ  = 4'd7,   // PC <= addr if zero set
        OUT = 4'd14,  // Output register <= A
        HLT = 4'd15   // Stop until reset
    } opcode_e;

    // Sequencer steps, six per instruction
    typedef enum logic [2:0] {
        T_IDLE = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T4     = 3'd4,
        T5     = 3'd5,
        T6     = 3'd6,
        T_HALT = 3'd7
    } tstate_e;

    // Which peer currently owns the shared bus
    typedef enum logic [2:0] {
        SRC_NONE, SRC_PC, SRC_IR, SRC_RAM, SRC_ACC, SRC_ALU
    } bus_src_e;

endpackage

// ==== design/program_counter.sv ====
// Program counter holding the fetch address
// Increments after fetch, loads from the jump address on JMP/JC/JZ
module program_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pc_inc,     // Step to next instruction
    input  logic                        pc_jump,    // Load jump_addr
    input  logic [cpu8_pkg::addr_w-1:0] jump_addr,  // Target taken from the bus
    output logic [cpu8_pkg::addr_w-1:0] pc_value
);

    logic [cpu8_pkg::addr_w-1:0] pc_q;

    // Jump wins over increment; wraps at 16 naturally
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (pc_jump) begin
            pc_q <= jump_addr;
        end else if (pc_inc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign pc_value = pc_q;  // Zero-extended onto the bus in the top level

    // A jump must never land in the same step as the fetch increment
    property p_no_jump_and_inc;
        @(posedge clk) disable iff (!rst_n)
            pc_jump |-> !pc_inc;
    endproperty
    a_no_jump_and_inc: assert property (p_no_jump_and_inc)
        else $error("PC jump and increment in the same cycle");

endmodule

// ==== design/control_block.sv ====
// Six-step micro-sequencer for the accumulator CPU
// Decodes the IR opcode into load strobes and bus requests per T-state
module control_block (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,         // Level, low holds the CPU in T_IDLE
    input  cpu8_pkg::opcode_e opcode,      // Upper nibble of IR
    input  logic              carry_flag,
    input  logic              zero_flag,
    output logic              mar_ld,
    output logic              ir_ld,
    output logic              acc_ld,
    output logic              b_ld,
    output logic              out_ld,
    output logic              ram_we,
    output logic              pc_inc,
    output logic              pc_jump,
    output logic              alu_sub,     // 1 selects A - B
    output logic              pc_req,
    output logic              ir_req,
    output logic              ram_req,
    output logic              acc_req,
    output logic              alu_req,
    output logic              out_valid,   // One cycle after out_ld
    output logic              halted
);

    cpu8_pkg::tstate_e state_q, state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= cpu8_pkg::T_IDLE;
            out_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            out_valid <= out_ld;  // Output register is valid the cycle after load
        end
    end

    // Step sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            cpu8_pkg::T_IDLE: state_d = run ? cpu8_pkg::T1 : cpu8_pkg::T_IDLE;
            cpu8_pkg::T1:     state_d = cpu8_pkg::T2;
            cpu8_pkg::T2:     state_d = cpu8_pkg::T3;
            cpu8_pkg::T3:     state_d = (opcode == cpu8_pkg::HLT) ? cpu8_pkg::T_HALT
                                                                  : cpu8_pkg::T4;
            cpu8_pkg::T4:     state_d = cpu8_pkg::T5;
            cpu8_pkg::T5:     state_d = cpu8_pkg::T6;
            cpu8_pkg::T6:     state_d = run ? cpu8_pkg::T1 : cpu8_pkg::T_IDLE;
            cpu8_pkg::T_HALT: state_d = cpu8_pkg::T_HALT;  // Left only by reset
            default:          state_d = cpu8_pkg::T_IDLE;
        endcase
    end

    // Strobes and requests, all low outside T1..T5
    always_comb begin
        {mar_ld, ir_ld, acc_ld, b_ld, out_ld, ram_we, pc_inc, pc_jump, alu_sub} = '0;
        {pc_req, ir_req, ram_req, acc_req, alu_req} = '0;
        case (state_q)
            cpu8_pkg::T1: begin  // PC to MAR
                pc_req = 1'b1;
                mar_ld = 1'b1;
            end
            cpu8_pkg::T2: begin  // RAM to IR, advance PC
                ram_req = 1'b1;
                ir_ld   = 1'b1;
                pc_inc  = 1'b1;
            end
            cpu8_pkg::T3: begin
                case (opcode)
                    cpu8_pkg::LDA, cpu8_pkg::ADD, cpu8_pkg::SUB, cpu8_pkg::STA: begin
                        ir_req = 1'b1;  // Operand address to MAR
                        mar_ld = 1'b1;
                    end
                    cpu8_pkg::LDI: begin
                        ir_req = 1'b1;
                        acc_ld = 1'b1;
                    end
                    cpu8_pkg::JMP: begin
                        ir_req  = 1'b1;
                        pc_jump = 1'b1;
                    end
                    cpu8_pkg::JC: begin
                        ir_req  = carry_flag;  // Branch resolved here
                        pc_jump = carry_flag;
                    end
                    cpu8_pkg::JZ: begin
                        ir_req  = zero_flag;
                        pc_jump = zero_flag;
                    end
                    default: ;  // OUT, HLT and unused codes
                endcase
            end
            cpu8_pkg::T4: begin
                case (opcode)
                    cpu8_pkg::LDA: begin
                        ram_req = 1'b1;
                        acc_ld  = 1'b1;
                    end
                    cpu8_pkg::ADD, cpu8_pkg::SUB: begin
                        ram_req = 1'b1;  // Operand into B
                        b_ld    = 1'b1;
                    end
                    cpu8_pkg::STA: begin
                        acc_req = 1'b1;
                        ram_we  = 1'b1;
                    end
                    cpu8_pkg::OUT: begin
                        acc_req = 1'b1;
                        out_ld  = 1'b1;
                    end
                    default: ;
                endcase
            end
            cpu8_pkg::T5: begin
                if (opcode == cpu8_pkg::ADD || opcode == cpu8_pkg::SUB) begin
                    alu_req = 1'b1;  // Result and flags captured at this edge
                    acc_ld  = 1'b1;
                    alu_sub = (opcode == cpu8_pkg::SUB);
                end
            end
            default: ;  // T_IDLE, T6 and T_HALT issue nothing
        endcase
    end

    assign halted = (state_q == cpu8_pkg::T_HALT);

    // A RAM store never shares its step with any register load
    a_no_store_with_load: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> !(mar_ld || ir_ld || acc_ld || b_ld || out_ld))
        else $error("Store and load issued on the same step");

endmodule

// ==== design/bus_arbiter.sv ====
// Shared bus arbiter, replaces the tri-state bus of the classic SAP design
// Fixed priority PC > IR > RAM > ACC > ALU, bus reads zero when idle
module bus_arbiter (
    input  logic                        clk,       // Only clocks the request check
    input  logic                        pc_req,
    input  logic                        ir_req,
    input  logic                        ram_req,
    input  logic                        acc_req,
    input  logic                        alu_req,
    input  logic [cpu8_pkg::data_w-1:0] pc_data,
    input  logic [cpu8_pkg::data_w-1:0] ir_data,
    input  logic [cpu8_pkg::data_w-1:0] ram_data,
    input  logic [cpu8_pkg::data_w-1:0] acc_data,
    input  logic [cpu8_pkg::data_w-1:0] alu_data,
    output cpu8_pkg::bus_src_e          grant,
    output logic [cpu8_pkg::data_w-1:0] bus
);

    // Priority encode the requests
    always_comb begin
        if (pc_req)       grant = cpu8_pkg::SRC_PC;
        else if (ir_req)  grant = cpu8_pkg::SRC_IR;
        else if (ram_req) grant = cpu8_pkg::SRC_RAM;
        else if (acc_req) grant = cpu8_pkg::SRC_ACC;
        else if (alu_req) grant = cpu8_pkg::SRC_ALU;
        else              grant = cpu8_pkg::SRC_NONE;
    end

    // Drive the winner's value
    always_comb begin
        case (grant)
            cpu8_pkg::SRC_PC:  bus = pc_data;
            cpu8_pkg::SRC_IR:  bus = ir_data;
            cpu8_pkg::SRC_RAM: bus = ram_data;
            cpu8_pkg::SRC_ACC: bus = acc_data;
            cpu8_pkg::SRC_ALU: bus = alu_data;
            default:           bus = '0;  // Nobody driving
        endcase
    end

    // Sequencer must never ask for two drivers in one step
    a_one_driver: assert property (@(posedge clk)
        $onehot0({pc_req, ir_req, ram_req, acc_req, alu_req}))
        else $error("More than one bus request active");

endmodule

// ==== design/alu_accumulator.sv ====
// Accumulator, B register and add/subtract ALU with carry and zero flags
// ALU output is combinational; flags latch only when the ALU result is loaded
module alu_accumulator (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [cpu8_pkg::data_w-1:0] bus,
    input  logic                        acc_ld,      // A <= bus
    input  logic                        b_ld,        // B <= bus
    input  logic                        alu_sub,     // 1 selects A - B
    input  logic                        alu_active,  // ALU owns the bus this cycle
    output logic [cpu8_pkg::data_w-1:0] acc_value,
    output logic [cpu8_pkg::data_w-1:0] alu_result,
    output logic                        carry_flag,
    output logic                        zero_flag
);

    logic [cpu8_pkg::data_w-1:0] a_q;
    logic [cpu8_pkg::data_w-1:0] b_q;
    logic [cpu8_pkg::data_w-1:0] b_eff;  // B or its complement
    logic [cpu8_pkg::data_w:0]   sum;    // Extra bit is the carry out

    // Data registers
    always_ff @(posedge clk) begin
        if (acc_ld) a_q <= bus;
        if (b_ld)   b_q <= bus;
    end

    // Subtract as A + ~B + 1, so carry out means no borrow
    assign b_eff      = alu_sub ? ~b_q : b_q;
    assign sum        = {1'b0, a_q} + {1'b0, b_eff} + {{cpu8_pkg::data_w{1'b0}}, alu_sub};
    assign alu_result = sum[cpu8_pkg::data_w-1:0];

    // Flags move on ADD and SUB only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_flag <= 1'b0;
            zero_flag  <= 1'b0;
        end else if (acc_ld && (alu_active || alu_sub)) begin
            carry_flag <= sum[cpu8_pkg::data_w];
            zero_flag  <= (alu_result == '0);
        end
    end

    assign acc_value = a_q;

endmodule

// ==== design/memory_unit.sv ====
// Memory address register and small RAM, with a program-load port
// Programs are written through prog_* while run is low
module memory_unit #(
    parameter int ram_bytes = 16  // 16 or 8 bytes
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    input  logic                        mar_ld,     // MAR <= bus low nibble
    input  logic                        ram_we,     // RAM[MAR] <= bus
    input  logic [cpu8_pkg::data_w-1:0] bus,
    input  logic                        prog_we,    // External loader write
    input  logic [cpu8_pkg::addr_w-1:0] prog_addr,
    input  logic [cpu8_pkg::data_w-1:0] prog_data,
    output logic [cpu8_pkg::data_w-1:0] ram_data    // RAM[MAR], combinational
);

    localparam int ram_aw = $clog2(ram_bytes);  // Index bits actually used

    logic [cpu8_pkg::addr_w-1:0] mar_q;
    logic [cpu8_pkg::data_w-1:0] mem [ram_bytes];
    logic [ram_aw-1:0]           mar_idx;
    logic [ram_aw-1:0]           prog_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else if (mar_ld) begin
            mar_q <= bus[cpu8_pkg::addr_w-1:0];
        end
    end

    // Upper address bits wrap on smaller RAMs
    assign mar_idx  = mar_q[ram_aw-1:0];
    assign prog_idx = prog_addr[ram_aw-1:0];

    // CPU store first, loader only while stopped
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[mar_idx] <= bus;
        end else if (prog_we && !run) begin
            mem[prog_idx] <= prog_data;
        end
    end

    assign ram_data = mem[mar_idx];

    a_no_load_while_running: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we |-> !run)
        else $error("Program write while running");

endmodule

// ==== design/cpu8_top.sv ====
// Top level of the 8-bit SAP-style CPU
// Wires the bus peers through the arbiter; holds the IR and output register
module cpu8_top #(
    parameter int ram_bytes = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    input  logic                        prog_we,
    input  logic [cpu8_pkg::addr_w-1:0] prog_addr,
    input  logic [cpu8_pkg::data_w-1:0] prog_data,
    output logic [cpu8_pkg::data_w-1:0] out_value,
    output logic                        out_valid,
    output logic                        halted
);

    logic [cpu8_pkg::data_w-1:0] bus;
    cpu8_pkg::bus_src_e          grant;
    logic [cpu8_pkg::data_w-1:0] ir_q;                   // Opcode | operand
    logic [cpu8_pkg::addr_w-1:0] pc_value;
    logic [cpu8_pkg::data_w-1:0] acc_value, alu_result, ram_data;
    logic carry_flag, zero_flag;
    logic mar_ld, ir_ld, acc_ld, b_ld, out_ld, ram_we;   // Load strobes
    logic pc_inc, pc_jump, alu_sub;
    logic pc_req, ir_req, ram_req, acc_req, alu_req;     // Bus requests

    program_counter u_pc (
        .clk, .rst_n, .pc_inc, .pc_jump,
        .jump_addr (bus[cpu8_pkg::addr_w-1:0]),  // Target comes off the bus from IR
        .pc_value
    );

    control_block u_ctrl (
        .clk, .rst_n, .run,
        .opcode (cpu8_pkg::opcode_e'(ir_q[7:4])),
        .carry_flag, .zero_flag,
        .mar_ld, .ir_ld, .acc_ld, .b_ld, .out_ld, .ram_we, .pc_inc, .pc_jump, .alu_sub,
        .pc_req, .ir_req, .ram_req, .acc_req, .alu_req,
        .out_valid, .halted
    );

    bus_arbiter u_arb (
        .clk, .pc_req, .ir_req, .ram_req, .acc_req, .alu_req,
        .pc_data  ({{(cpu8_pkg::data_w-cpu8_pkg::addr_w){1'b0}}, pc_value}),
        .ir_data  ({{(cpu8_pkg::data_w-cpu8_pkg::addr_w){1'b0}}, ir_q[3:0]}),  // Operand only
        .ram_data, .acc_data (acc_value), .alu_data (alu_result),
        .grant, .bus
    );

    alu_accumulator u_alu (
        .clk, .rst_n, .bus, .acc_ld, .b_ld, .alu_sub,
        .alu_active (grant == cpu8_pkg::SRC_ALU),
        .acc_value, .alu_result, .carry_flag, .zero_flag
    );

    memory_unit #(.ram_bytes(ram_bytes)) u_mem (
        .clk, .rst_n, .run, .mar_ld, .ram_we, .bus,
        .prog_we, .prog_addr, .prog_data, .ram_data
    );

    // Instruction and output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_q      <= '0;
            out_value <= '0;
        end else begin
            if (ir_ld)  ir_q      <= bus;
            if (out_ld) out_value <= bus;  // Shown with out_valid next cycle
        end
    end

endmodule

// ==== verif/cpu8_tb_checks.svh ====
// Compare tasks and program-image helpers for the CPU testbench
// Included inside cpu8_tb; relies on its counters, clock and program port
`ifndef CPU8_TB_CHECKS_SVH
`define CPU8_TB_CHECKS_SVH

task automatic check_byte(input string name, input logic [cpu8_pkg::data_w-1:0] got,
                          input logic [cpu8_pkg::data_w-1:0] expected);
    checks_total++;
    if (got !== expected) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
        errors_total++;
        test_errors++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
    checks_total++;
    if (got !== expected) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
        errors_total++;
        test_errors++;
    end
endtask

task automatic check_count(input string name, input int got, input int expected);
    checks_total++;
    if (got != expected) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
        errors_total++;
        test_errors++;
    end
endtask

// Opcode in the upper nibble, operand in the lower
function automatic logic [cpu8_pkg::data_w-1:0] encode_instr(input cpu8_pkg::opcode_e op,
                                                             input logic [3:0] operand);
    return {op, operand};
endfunction

// Unused bytes become HLT with their own address as operand
function automatic void fill_image();
    for (int i = 0; i < 16; i++) begin
        image[i] = encode_instr(cpu8_pkg::HLT, i[3:0]);
    end
endfunction

task automatic write_byte(input logic [3:0] addr, input logic [cpu8_pkg::data_w-1:0] data);
    @(negedge clk);
    prog_we   = 1'b1;
    prog_addr = addr;
    prog_data = data;
    @(negedge clk);
    prog_we   = 1'b0;  // One write per strobe
endtask

task automatic load_program();
    for (int i = 0; i < 16; i++) begin
        write_byte(i[3:0], image[i]);
    end
endtask

`endif

// ==== verif/cpu8_tb.sv ====
// Directed testbench for the 8-bit accumulator CPU
// Each test loads a program, runs it to HLT and checks the OUT stream
module cpu8_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int instr_budget = 202;                     // Worst case over all tests
    localparam int cycle_limit  = instr_budget * 6 + 200;  // Six cycles per instruction

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        run;
    logic                        prog_we;
    logic [cpu8_pkg::addr_w-1:0] prog_addr;
    logic [cpu8_pkg::data_w-1:0] prog_data;
    logic [cpu8_pkg::data_w-1:0] out_value;
    logic                        out_valid;
    logic                        halted;

    logic [cpu8_pkg::data_w-1:0] image [16];     // Program staged before loading
    logic [cpu8_pkg::data_w-1:0] outputs [$];     // Values seen with out_valid
    logic [cpu8_pkg::data_w-1:0] expected_q [$];
    logic [31:0]                 lfsr_state = 32'hbd39_9d50;
    int                          busy_cycles = 0;
    int                          checks_total = 0;
    int                          errors_total = 0;
    int                          test_errors = 0;
    int                          tests_run = 0;

    `include "cpu8_tb_checks.svh"

    cpu8_top #(.ram_bytes(16)) u_cpu8_top (
        .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
        .out_value, .out_valid, .halted
    );

    always #5 clk = ~clk;

    // Only cycles with run high count toward the limit
    always @(posedge clk) begin
        if (run) busy_cycles++;
        if (busy_cycles > cycle_limit) begin
            $display("Timeout: CPU still running after %0d cycles", busy_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0]) stepped = stepped ^ 32'h8020_0003;
        return stepped;
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[6:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n   = 1'b0;
        run     = 1'b0;
        prog_we = 1'b0;
        repeat (2) @(negedge clk);
        rst_n   = 1'b1;
    endtask

    // Raise run and gather outputs until the CPU halts
    task automatic run_program();
        outputs.delete();
        @(negedge clk);
        run = 1'b1;
        do begin
            @(negedge clk);
            if (out_valid) outputs.push_back(out_value);
        end while (!halted);
        run = 1'b0;
    endtask

    task automatic compare_outputs();
        check_count("output count", outputs.size(), expected_q.size());
        for (int i = 0; i < expected_q.size() && i < outputs.size(); i++) begin
            check_byte("out_value", outputs[i], expected_q[i]);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) $display("%-10s ok", name);
        else $display("%-10s %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // LDA, ADD, OUT, then JC reports the carry as a second output
    task automatic test_add();
        logic [7:0] a, b;
        logic [8:0] total;
        for (int i = 0; i < 8; i++) begin
            a = random_bits(8);
            b = random_bits(8);
            if (i == 6) b = 8'd0 - a;  // Sum wraps to zero
            if (i == 7) begin
                a[7] = 1'b1;            // Carry out guaranteed
                b[7] = 1'b1;
            end
            apply_reset();
            fill_image();
            image[0]  = encode_instr(cpu8_pkg::LDA, 4'd14);
            image[1]  = encode_instr(cpu8_pkg::ADD, 4'd15);
            image[2]  = encode_instr(cpu8_pkg::OUT, 4'd0);
            image[3]  = encode_instr(cpu8_pkg::JC, 4'd5);
            image[5]  = encode_instr(cpu8_pkg::LDI, 4'd1);
            image[6]  = encode_instr(cpu8_pkg::OUT, 4'd0);
            image[14] = a;
            image[15] = b;
            load_program();
            run_program();
            total = {1'b0, a} + {1'b0, b};
            expected_q.delete();
            expected_q.push_back(total[7:0]);
            if (total[8]) expected_q.push_back(8'd1);
            compare_outputs();
        end
        report_test("add");
    endtask

    // Count down by d, JZ leaves at zero, JC stops on a borrow
    task automatic test_countdown();
        logic [7:0] a, d, n;
        logic       carry;
        logic       done;
        for (int k = 0; k < 2; k++) begin
            n = random_bits(4);
            d = (k == 0) ? 8'd1 : 8'd1 + random_bits(2);
            apply_reset();
            fill_image();
            image[0]  = encode_instr(cpu8_pkg::LDI, n[3:0]);
            image[1]  = encode_instr(cpu8_pkg::OUT, 4'd0);
            image[2]  = encode_instr(cpu8_pkg::SUB, 4'd15);
            image[3]  = encode_instr(cpu8_pkg::JZ, 4'd6);
            image[4]  = encode_instr(cpu8_pkg::JC, 4'd1);
            image[6]  = encode_instr(cpu8_pkg::OUT, 4'd0);
            image[15] = d;
            load_program();
            run_program();
            expected_q.delete();
            a    = n;
            done = 1'b0;
            while (!done) begin
                expected_q.push_back(a);
                carry = (a >= d);  // Set when there is no borrow
                a     = a - d;
                if (a == 8'd0) begin
                    expected_q.push_back(a);  // Exit path prints the zero
                    done = 1'b1;
                end else if (!carry) begin
                    done = 1'b1;
                end
            end
            compare_outputs();
        end
        report_test("countdown");
    endtask

    task automatic test_store();
        logic [7:0] x;
        x = random_bits(8);
        apply_reset();
        fill_image();
        image[0]  = encode_instr(cpu8_pkg::LDA, 4'd14);
        image[1]  = encode_instr(cpu8_pkg::STA, 4'd13);
        image[2]  = encode_instr(cpu8_pkg::LDI, 4'd0);  // Clear A before reading back
        image[3]  = encode_instr(cpu8_pkg::LDA, 4'd13);
        image[4]  = encode_instr(cpu8_pkg::OUT, 4'd0);
        image[14] = x;
        load_program();
        run_program();
        expected_q.delete();
        expected_q.push_back(x);
        compare_outputs();
        report_test("store");
    endtask

    task automatic test_jump();
        logic [7:0] p, q;
        p = random_bits(4);
        q = random_bits(4);
        apply_reset();
        fill_image();
        image[0] = encode_instr(cpu8_pkg::LDI, p[3:0]);
        image[1] = encode_instr(cpu8_pkg::JMP, 4'd3);
        image[2] = encode_instr(cpu8_pkg::OUT, 4'd0);  // Skipped
        image[3] = encode_instr(cpu8_pkg::LDI, q[3:0]);
        image[4] = encode_instr(cpu8_pkg::OUT, 4'd0);
        load_program();
        run_program();
        expected_q.delete();
        expected_q.push_back(q);
        compare_outputs();
        report_test("jump");
    endtask

    task automatic test_halt();
        logic [7:0] v;
        v = random_bits(4) | 8'h01;  // Nonzero so the reset clear is visible
        apply_reset();
        fill_image();
        image[0] = encode_instr(cpu8_pkg::LDI, v[3:0]);
        image[1] = encode_instr(cpu8_pkg::OUT, 4'd0);
        load_program();
        run_program();
        expected_q.delete();
        expected_q.push_back(v);
        compare_outputs();
        repeat (50) begin
            @(negedge clk);
            check_flag("halted", halted, 1'b1);
            check_flag("out_valid", out_valid, 1'b0);
        end
        check_byte("out_value", out_value, v);
        apply_reset();
        check_flag("halted", halted, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        check_byte("out_value", out_value, 8'd0);
        report_test("halt");
    endtask

    // RAM survives reset, so one loader write changes the next run
    task automatic test_reload();
        logic [7:0] x, y, z;
        x = random_bits(8);
        y = random_bits(8);
        z = random_bits(8);
        if (z == y) z = ~y;
        apply_reset();
        fill_image();
        image[0]  = encode_instr(cpu8_pkg::LDA, 4'd15);
        image[1]  = encode_instr(cpu8_pkg::ADD, 4'd14);
        image[2]  = encode_instr(cpu8_pkg::OUT, 4'd0);
        image[14] = y;
        image[15] = x;
        load_program();
        run_program();
        expected_q.delete();
        expected_q.push_back(x + y);
        compare_outputs();
        apply_reset();
        write_byte(4'd14, z);
        run_program();
        expected_q.delete();
        expected_q.push_back(x + z);
        compare_outputs();
        report_test("reload");
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_add();
        test_countdown();
        test_store();
        test_jump();
        test_halt();
        test_reload();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks_total, errors_total);
        if (errors_total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cpu8_top.f ====
+incdir+verif
design/cpu8_pkg.sv
design/program_counter.sv
design/control_block.sv
design/bus_arbiter.sv
design/alu_accumulator.sv
design/memory_unit.sv
design/cpu8_top.sv
verif/cpu8_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the CPU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f cpu8_top.f --top-module cpu8_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vcpu8_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
